//--- source/card_game_defs.svh
// ======================================================================
// High/low card game constants
// ======================================================================
`ifndef CARD_GAME_DEFS_SVH
`define CARD_GAME_DEFS_SVH

// datapath widths
`define CARD_W 4
`define AMOUNT_W 7
`define SEG_W 7

// chip accounting
`define CHIPS_START 7'd20
`define AMOUNT_MAX 7'd127

// stake per bet code, code 0 bets nothing
`define STAKE_1 7'd5
`define STAKE_2 7'd10
`define STAKE_3 7'd20

// nonzero start value for the card generator
`define LFSR_SEED 16'hACE1

`endif

//--- source/card_game_pkg.sv
// ======================================================================
// Card game shared types
// ======================================================================
`default_nettype none

`include "card_game_defs.svh"

package card_game_pkg;

	typedef logic [`CARD_W-1:0] card_t;
	typedef logic [`AMOUNT_W-1:0] amount_t;
	typedef logic [1:0] bet_code_t;
	// segments are active low
	typedef logic [`SEG_W-1:0] segments_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_START_RELEASE,
		ST_BET_WAIT,
		ST_BET_RELEASE,
		ST_DEAL_UP,
		ST_DEAL_DOWN,
		ST_GUESS_WAIT,
		ST_GUESS_RELEASE,
		ST_JUDGE,
		ST_AWAIT_RESULT,
		ST_CONT_WAIT,
		ST_CONT_RELEASE,
		ST_SETTLE
	} round_state_t;

endpackage

`default_nettype wire

//--- source/card_lfsr.sv
// ======================================================================
// Card value generator
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "card_game_defs.svh"

module card_lfsr (
	input logic Clock,
	input logic reset,
	output card_game_pkg::card_t random_card
);

	logic [15:0] shift_reg;
	logic feedback;

	// taps 0, 2, 3, 5 fed back into the top bit
	assign feedback = shift_reg[0] ^ shift_reg[2] ^ shift_reg[3] ^ shift_reg[5];

	always_ff @(posedge Clock) begin
		if (reset) begin
			shift_reg <= `LFSR_SEED;
		end else begin
			shift_reg <= {feedback, shift_reg[15:1]};
		end
	end

	// middle bits make the card
	assign random_card = shift_reg[10:7];

endmodule

`default_nettype wire

//--- source/round_control.sv
// ======================================================================
// Round sequencing FSM
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module round_control (
	input logic Clock,
	input logic reset,
	input logic go,
	input logic load_bet,
	input logic load_guess,
	input logic cont_key,
	input logic keep_going,
	input logic won,
	input logic won_valid,
	output logic load_stake,
	output logic deal_up,
	output logic deal_down,
	output logic latch_guess,
	output logic judge,
	output logic cash_in
);

	card_game_pkg::round_state_t state;
	card_game_pkg::round_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			card_game_pkg::ST_IDLE:
				if (go) next_state = card_game_pkg::ST_START_RELEASE;
			card_game_pkg::ST_START_RELEASE:
				if (!go) next_state = card_game_pkg::ST_BET_WAIT;
			card_game_pkg::ST_BET_WAIT:
				if (load_bet) next_state = card_game_pkg::ST_BET_RELEASE;
			card_game_pkg::ST_BET_RELEASE:
				if (!load_bet) next_state = card_game_pkg::ST_DEAL_UP;
			card_game_pkg::ST_DEAL_UP:
				next_state = card_game_pkg::ST_DEAL_DOWN;
			card_game_pkg::ST_DEAL_DOWN:
				next_state = card_game_pkg::ST_GUESS_WAIT;
			card_game_pkg::ST_GUESS_WAIT:
				if (load_guess) next_state = card_game_pkg::ST_GUESS_RELEASE;
			card_game_pkg::ST_GUESS_RELEASE:
				if (!load_guess) next_state = card_game_pkg::ST_JUDGE;
			card_game_pkg::ST_JUDGE:
				next_state = card_game_pkg::ST_AWAIT_RESULT;
			card_game_pkg::ST_AWAIT_RESULT:
				// a loss settles straight away
				if (won_valid) begin
					next_state = won ? card_game_pkg::ST_CONT_WAIT : card_game_pkg::ST_SETTLE;
				end
			card_game_pkg::ST_CONT_WAIT:
				if (cont_key) next_state = card_game_pkg::ST_CONT_RELEASE;
			card_game_pkg::ST_CONT_RELEASE:
				if (!cont_key) begin
					next_state = keep_going ? card_game_pkg::ST_DEAL_UP
						: card_game_pkg::ST_SETTLE;
				end
			card_game_pkg::ST_SETTLE:
				next_state = card_game_pkg::ST_BET_WAIT;
			default:
				next_state = card_game_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= card_game_pkg::ST_IDLE;
			load_stake <= 1'b0;
			latch_guess <= 1'b0;
		end else begin
			state <= next_state;
			// press edges give one-cycle strobes, the wait state is left at once
			load_stake <= (state == card_game_pkg::ST_BET_WAIT) && load_bet;
			latch_guess <= (state == card_game_pkg::ST_GUESS_WAIT) && load_guess;
		end
	end

	// single-cycle states drive their strobes directly
	assign deal_up = (state == card_game_pkg::ST_DEAL_UP);
	assign deal_down = (state == card_game_pkg::ST_DEAL_DOWN);
	assign judge = (state == card_game_pkg::ST_JUDGE);
	assign cash_in = (state == card_game_pkg::ST_SETTLE);

endmodule

`default_nettype wire

//--- source/card_table.sv
// ======================================================================
// Deal, guess and judgement
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module card_table (
	input logic Clock,
	input logic reset,
	input logic deal_up,
	input logic deal_down,
	input logic latch_guess,
	input logic judge,
	input logic guess,
	input card_game_pkg::card_t random_card,
	output card_game_pkg::card_t face_up,
	output card_game_pkg::card_t face_down,
	output logic won,
	output logic won_valid
);

	logic guess_high;
	logic is_high;

	// equal counts as high
	assign is_high = (face_down >= face_up);

	always_ff @(posedge Clock) begin
		if (reset) begin
			face_up <= 4'd9;
			face_down <= 4'd0;
			guess_high <= 1'b0;
			won <= 1'b0;
			won_valid <= 1'b0;
		end else begin
			if (deal_up) face_up <= random_card;
			if (deal_down) face_down <= random_card;
			if (latch_guess) guess_high <= guess;
			if (judge) won <= (guess_high == is_high);
			won_valid <= judge;
		end
	end

endmodule

`default_nettype wire

//--- source/wager_ledger.sv
// ======================================================================
// Stake and chip bookkeeping
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "card_game_defs.svh"

module wager_ledger (
	input logic Clock,
	input logic reset,
	input logic load_stake,
	input logic won,
	input logic won_valid,
	input logic cash_in,
	input card_game_pkg::bet_code_t bet_code,
	output card_game_pkg::amount_t stake,
	output card_game_pkg::amount_t chips
);

	card_game_pkg::amount_t bet_cost;
	logic [`AMOUNT_W:0] doubled;
	logic [`AMOUNT_W:0] cashed;

	always_comb begin
		case (bet_code)
			2'd1: bet_cost = `STAKE_1;
			2'd2: bet_cost = `STAKE_2;
			2'd3: bet_cost = `STAKE_3;
			default: bet_cost = '0;
		endcase
	end

	// one extra bit to catch overflow before saturating
	assign doubled = {stake, 1'b0};
	assign cashed = {1'b0, chips} + {1'b0, stake};

	always_ff @(posedge Clock) begin
		if (reset) begin
			stake <= '0;
			chips <= `CHIPS_START;
		end else if (load_stake) begin
			if (bet_cost <= chips) begin
				stake <= bet_cost;
				chips <= chips - bet_cost;
			end else begin
				// can't afford it, bet nothing
				stake <= '0;
			end
		end else if (won_valid) begin
			if (!won) stake <= '0;
			else if (doubled > {1'b0, `AMOUNT_MAX}) stake <= `AMOUNT_MAX;
			else stake <= doubled[`AMOUNT_W-1:0];
		end else if (cash_in) begin
			chips <= (cashed > {1'b0, `AMOUNT_MAX}) ? `AMOUNT_MAX : cashed[`AMOUNT_W-1:0];
			stake <= '0;
		end
	end

endmodule

`default_nettype wire

//--- source/seven_seg_display.sv
// ======================================================================
// Six digit hex display
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "card_game_defs.svh"

module seven_seg_display (
	input logic Clock,
	input logic reset,
	input card_game_pkg::card_t face_up,
	input card_game_pkg::card_t face_down,
	input card_game_pkg::amount_t stake,
	input card_game_pkg::amount_t chips,
	output card_game_pkg::segments_t hex0,
	output card_game_pkg::segments_t hex1,
	output card_game_pkg::segments_t hex2,
	output card_game_pkg::segments_t hex3,
	output card_game_pkg::segments_t hex4,
	output card_game_pkg::segments_t hex5
);

	// active-low segments, bit 6 is g
	function automatic card_game_pkg::segments_t hex_to_seg(input logic [3:0] digit);
		case (digit)
			4'h0: hex_to_seg = 7'b100_0000;
			4'h1: hex_to_seg = 7'b111_1001;
			4'h2: hex_to_seg = 7'b010_0100;
			4'h3: hex_to_seg = 7'b011_0000;
			4'h4: hex_to_seg = 7'b001_1001;
			4'h5: hex_to_seg = 7'b001_0010;
			4'h6: hex_to_seg = 7'b000_0010;
			4'h7: hex_to_seg = 7'b111_1000;
			4'h8: hex_to_seg = 7'b000_0000;
			4'h9: hex_to_seg = 7'b001_1000;
			4'hA: hex_to_seg = 7'b000_1000;
			4'hB: hex_to_seg = 7'b000_0011;
			4'hC: hex_to_seg = 7'b100_0110;
			4'hD: hex_to_seg = 7'b010_0001;
			4'hE: hex_to_seg = 7'b000_0110;
			default: hex_to_seg = 7'b000_1110;
		endcase
	endfunction

	always_ff @(posedge Clock) begin
		if (reset) begin
			hex0 <= '1;
			hex1 <= '1;
			hex2 <= '1;
			hex3 <= '1;
			hex4 <= '1;
			hex5 <= '1;
		end else begin
			hex5 <= hex_to_seg(face_up);
			hex4 <= hex_to_seg(face_down);
			// amounts split into upper 3 and lower 4 bits
			hex3 <= hex_to_seg({1'b0, stake[`AMOUNT_W-1:4]});
			hex2 <= hex_to_seg(stake[3:0]);
			hex1 <= hex_to_seg({1'b0, chips[`AMOUNT_W-1:4]});
			hex0 <= hex_to_seg(chips[3:0]);
		end
	end

endmodule

`default_nettype wire

//--- source/card_game_top.sv
// ======================================================================
// High/low card game top level
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module card_game_top (
	input logic Clock,
	input logic reset,
	input logic go,
	input logic load_bet,
	input logic load_guess,
	input logic guess,
	input logic cont_key,
	input logic keep_going,
	input card_game_pkg::bet_code_t bet_sw,
	output card_game_pkg::segments_t hex0,
	output card_game_pkg::segments_t hex1,
	output card_game_pkg::segments_t hex2,
	output card_game_pkg::segments_t hex3,
	output card_game_pkg::segments_t hex4,
	output card_game_pkg::segments_t hex5,
	output logic won_led
);

	card_game_pkg::card_t random_card;
	card_game_pkg::card_t face_up;
	card_game_pkg::card_t face_down;
	card_game_pkg::amount_t stake;
	card_game_pkg::amount_t chips;
	logic load_stake;
	logic deal_up;
	logic deal_down;
	logic latch_guess;
	logic judge;
	logic cash_in;
	logic won;
	logic won_valid;

	card_lfsr u_lfsr (
		.Clock(Clock),
		.reset(reset),
		.random_card(random_card)
	);

	round_control u_control (
		.Clock(Clock),
		.reset(reset),
		.go(go),
		.load_bet(load_bet),
		.load_guess(load_guess),
		.cont_key(cont_key),
		.keep_going(keep_going),
		.won(won),
		.won_valid(won_valid),
		.load_stake(load_stake),
		.deal_up(deal_up),
		.deal_down(deal_down),
		.latch_guess(latch_guess),
		.judge(judge),
		.cash_in(cash_in)
	);

	card_table u_table (
		.Clock(Clock),
		.reset(reset),
		.deal_up(deal_up),
		.deal_down(deal_down),
		.latch_guess(latch_guess),
		.judge(judge),
		.guess(guess),
		.random_card(random_card),
		.face_up(face_up),
		.face_down(face_down),
		.won(won),
		.won_valid(won_valid)
	);

	wager_ledger u_ledger (
		.Clock(Clock),
		.reset(reset),
		.load_stake(load_stake),
		.won(won),
		.won_valid(won_valid),
		.cash_in(cash_in),
		.bet_code(bet_sw),
		.stake(stake),
		.chips(chips)
	);

	seven_seg_display u_display (
		.Clock(Clock),
		.reset(reset),
		.face_up(face_up),
		.face_down(face_down),
		.stake(stake),
		.chips(chips),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	// last judgement
	assign won_led = won;

endmodule

`default_nettype wire

//--- dv/card_game_sva.sv
// ======================================================================
// Control and ledger assertions
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "card_game_defs.svh"

module card_game_sva #(
	parameter bit LEDGER_SIDE = 1'b0
) (
	input logic Clock,
	input logic reset,
	input logic [5:0] strobes,
	input logic judge,
	input logic won_valid,
	input card_game_pkg::amount_t chips
);

	int unsigned failures;

	initial failures = 0;

	strobes_exclusive: assert property (@(posedge Clock) disable iff (reset)
		$onehot0(strobes))
		else begin
			$error("more than one control strobe high");
			failures++;
		end

	generate
		if (LEDGER_SIDE) begin : g_ledger
			chips_in_range: assert property (@(posedge Clock) disable iff (reset)
				chips <= `AMOUNT_MAX)
				else begin
					$error("chips above limit");
					failures++;
				end
		end else begin : g_control
			// won_valid is exactly judge delayed by one cycle
			result_after_judge: assert property (@(posedge Clock) disable iff (reset)
				judge |=> won_valid)
				else begin
					$error("won_valid missing after judge");
					failures++;
				end

			result_only_after_judge: assert property (@(posedge Clock) disable iff (reset)
				won_valid |-> $past(judge))
				else begin
					$error("won_valid without judge one cycle before");
					failures++;
				end
		end
	endgenerate

endmodule

// result pulse checked in the control, chip limit in the ledger
bind round_control card_game_sva #(.LEDGER_SIDE(1'b0)) u_control_sva (
	.Clock(Clock),
	.reset(reset),
	.strobes({load_stake, deal_up, deal_down, latch_guess, judge, cash_in}),
	.judge(judge),
	.won_valid(won_valid),
	.chips(7'd0)
);

bind wager_ledger card_game_sva #(.LEDGER_SIDE(1'b1)) u_ledger_sva (
	.Clock(Clock),
	.reset(reset),
	.strobes({load_stake, won_valid, cash_in, 3'b000}),
	.judge(1'b0),
	.won_valid(1'b0),
	.chips(chips)
);

`default_nettype wire

//--- dv/tb_clock_gen.sv
// ======================================================================
// Testbench clock and reset
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic Clock,
	output logic reset
);

	// 10 ns period
	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// released on a falling edge after 10 rising edges
	initial begin
		reset = 1'b1;
		repeat (10) @(negedge Clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/card_game_checker.sv
// ======================================================================
// Card game scoreboard
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "card_game_defs.svh"

module card_game_checker (
	input card_game_pkg::segments_t hex0,
	input card_game_pkg::segments_t hex1,
	input card_game_pkg::segments_t hex2,
	input card_game_pkg::segments_t hex3,
	input card_game_pkg::segments_t hex4,
	input card_game_pkg::segments_t hex5,
	input logic won_led
);

	int model_stake;
	int model_chips;
	int face_up;
	int face_down;
	logic model_won;
	int error_count;
	int check_count;

	initial begin
		model_stake = 0;
		model_chips = `CHIPS_START;
		face_up = 0;
		face_down = 0;
		model_won = 1'b0;
		error_count = 0;
		check_count = 0;
	end

	// standard active-low hex patterns, g is the top bit
	function automatic int seg_to_digit(input card_game_pkg::segments_t seg);
		case (seg)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0011000: return 9;
			7'b0001000: return 10;
			7'b0000011: return 11;
			7'b1000110: return 12;
			7'b0100001: return 13;
			7'b0000110: return 14;
			7'b0001110: return 15;
			default: return -1;
		endcase
	endfunction

	function automatic int saturate(input int value);
		return (value > `AMOUNT_MAX) ? `AMOUNT_MAX : value;
	endfunction

	task automatic note_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic compare_value(input string name, input int actual, input int expected);
		check_count++;
		if (actual != expected) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic read_digit(input card_game_pkg::segments_t seg, input string name,
		output int value);
		value = seg_to_digit(seg);
		if (value < 0) begin
			note_failure($sformatf("%s does not show a hex digit", name));
		end
	endtask

	task automatic compare_amounts();
		int upper;
		int lower;
		read_digit(hex3, "hex3", upper);
		read_digit(hex2, "hex2", lower);
		compare_value("stake", upper * 16 + lower, model_stake);
		read_digit(hex1, "hex1", upper);
		read_digit(hex0, "hex0", lower);
		compare_value("chips", upper * 16 + lower, model_chips);
	endtask

	task automatic capture_faces();
		read_digit(hex5, "hex5", face_up);
		read_digit(hex4, "hex4", face_down);
	endtask

	task automatic check_reset();
		compare_amounts();
		compare_value("won_led", int'(won_led), 0);
		// cards before the first deal
		capture_faces();
		compare_value("face_up", face_up, 9);
		compare_value("face_down", face_down, 0);
	endtask

	task automatic check_bet(input int code);
		int cost;
		case (code)
			1: cost = `STAKE_1;
			2: cost = `STAKE_2;
			3: cost = `STAKE_3;
			default: cost = 0;
		endcase
		// unaffordable stake loads as zero
		if (cost <= model_chips) begin
			model_stake = cost;
			model_chips = model_chips - cost;
		end else begin
			model_stake = 0;
		end
		compare_amounts();
		capture_faces();
	endtask

	task automatic check_judgement(input logic guess_high);
		model_won = (guess_high == (face_down >= face_up));
		compare_value("won_led", int'(won_led), int'(model_won));
		if (model_won) begin
			model_stake = saturate(2 * model_stake);
		end else begin
			// loss settles at once with nothing left to cash
			model_stake = 0;
		end
		compare_amounts();
	endtask

	task automatic check_continue(input logic keep_going);
		if (keep_going) begin
			compare_amounts();
			capture_faces();
		end else begin
			model_chips = saturate(model_chips + model_stake);
			model_stake = 0;
			compare_amounts();
		end
	endtask

endmodule

`default_nettype wire

//--- dv/card_game_tb.sv
// ======================================================================
// High/low card game testbench
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module card_game_tb;

	localparam int MAX_ROUNDS = 32;
	localparam int KEY_GO = 0;
	localparam int KEY_BET = 1;
	localparam int KEY_GUESS = 2;
	localparam int KEY_CONT = 3;

	logic Clock;
	logic reset;
	logic go;
	logic load_bet;
	logic load_guess;
	logic guess;
	logic cont_key;
	logic keep_going;
	card_game_pkg::bet_code_t bet_sw;
	card_game_pkg::segments_t hex0;
	card_game_pkg::segments_t hex1;
	card_game_pkg::segments_t hex2;
	card_game_pkg::segments_t hex3;
	card_game_pkg::segments_t hex4;
	card_game_pkg::segments_t hex5;
	logic won_led;

	// three words per round: bet code, guess, keep_going
	logic [3:0] vectors [0:3*MAX_ROUNDS-1];
	int round_count;
	int cycle_count;
	int cycle_limit;
	int assertion_failures;
	int total_errors;
	logic need_bet;
	logic guess_high;

	tb_clock_gen u_clock_gen (
		.Clock(Clock),
		.reset(reset)
	);

	card_game_top u_dut (
		.Clock(Clock),
		.reset(reset),
		.go(go),
		.load_bet(load_bet),
		.load_guess(load_guess),
		.guess(guess),
		.cont_key(cont_key),
		.keep_going(keep_going),
		.bet_sw(bet_sw),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.won_led(won_led)
	);

	card_game_checker u_checker (
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.won_led(won_led)
	);

	task automatic set_key(input int key_id, input logic level);
		case (key_id)
			KEY_GO: go = level;
			KEY_BET: load_bet = level;
			KEY_GUESS: load_guess = level;
			default: cont_key = level;
		endcase
	endtask

	// called right after a falling edge
	task automatic press_key(input int key_id);
		set_key(key_id, 1'b1);
		repeat (2) @(negedge Clock);
		set_key(key_id, 1'b0);
		repeat (6) @(negedge Clock);
	endtask

	// 0 and 1 are literal, 2 picks the winning side, 3 the losing side
	function automatic logic choose_guess(input logic [3:0] code);
		logic high;
		high = (u_checker.face_down >= u_checker.face_up);
		case (code)
			4'd0: return 1'b0;
			4'd1: return 1'b1;
			4'd2: return high;
			default: return !high;
		endcase
	endfunction

	always @(posedge Clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: run exceeded %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		go = 1'b0;
		load_bet = 1'b0;
		load_guess = 1'b0;
		guess = 1'b0;
		cont_key = 1'b0;
		keep_going = 1'b0;
		bet_sw = 2'd0;
		cycle_count = 0;
		cycle_limit = 0;
		round_count = 0;
		need_bet = 1'b1;
		for (int i = 0; i < 3 * MAX_ROUNDS; i++) begin
			vectors[i] = 4'hf;
		end
		$readmemh("dv/card_game_vectors.txt", vectors);
		while (round_count < MAX_ROUNDS && vectors[3 * round_count] != 4'hf) begin
			round_count++;
		end
		cycle_limit = 40 * round_count + 100;
		if (round_count == 0) begin
			u_checker.note_failure("vector file held no rounds");
		end

		@(negedge Clock);
		while (reset) @(negedge Clock);
		// display registers need a cycle to fill
		repeat (3) @(negedge Clock);
		u_checker.check_reset();
		press_key(KEY_GO);

		for (int r = 0; r < round_count; r++) begin
			if (need_bet) begin
				bet_sw = vectors[3 * r][1:0];
				press_key(KEY_BET);
				u_checker.check_bet(int'(bet_sw));
			end
			guess_high = choose_guess(vectors[3 * r + 1]);
			guess = guess_high;
			press_key(KEY_GUESS);
			u_checker.check_judgement(guess_high);
			if (u_checker.model_won) begin
				keep_going = vectors[3 * r + 2][0];
				press_key(KEY_CONT);
				u_checker.check_continue(keep_going);
				need_bet = !keep_going;
			end else begin
				need_bet = 1'b1;
			end
		end

		assertion_failures = u_dut.u_control.u_control_sva.failures
			+ u_dut.u_ledger.u_ledger_sva.failures;
		total_errors = u_checker.error_count + assertion_failures;
		$display("checks: %0d, checker errors: %0d, assertion failures: %0d",
			u_checker.check_count, u_checker.error_count, assertion_failures);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/card_game_vectors.txt
// columns: bet_code guess keep_going, one round per line
// guess 0 low, 1 high, 2 the winning side, 3 the losing side
1 2 0
2 3 0
3 2 0
2 2 1
0 2 1
0 2 1
0 2 1
0 2 0
3 2 0
0 1 0
1 0 1
1 3 0
2 2 0

//--- compile.f
+incdir+source
source/card_game_pkg.sv
source/card_lfsr.sv
source/round_control.sv
source/card_table.sv
source/wager_ledger.sv
source/seven_seg_display.sv
source/card_game_top.sv
dv/card_game_sva.sv
dv/tb_clock_gen.sv
dv/card_game_checker.sv
dv/card_game_tb.sv
